// ==== include/soc_macros.svh ====
// SoC address map and sizing
// Base addresses, memory depth, reset hold length and control bit positions

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Address map ============================
// Only address bits 31:28 select the slave
`define SOC_MEM_BASE      32'h0000_0000
`define SOC_GPIO_BASE     32'h1000_0000
`define SOC_CTRL_BASE     32'h2000_0000

// On-chip memory, indexed by address bits 11:2
`define SOC_MEM_WORDS     1024

// Internal reset hold in sys_clk cycles
`define SOC_RST_CYCLES    100

// System control block
`define SOC_ID_VALUE      32'h4D58_0001
`define CTL_CPU_RST_BIT   3
`define CTL_SYS_RST_BIT   7

`endif

// ==== logic/soc_bus_pkg.sv ====
// Bus traffic types
// Word and strobe types of the valid/ready memory bus, and the
// decoder's slave selection

package soc_bus_pkg;

  // Data and address word
  typedef logic [31:0] bus_word_t;

  // Byte strobe, all zero for a read
  typedef logic [3:0] bus_strb_t;

  // Decoder result
  typedef enum logic [1:0] {
    SEL_MEM  = 2'd0,
    SEL_GPIO = 2'd1,
    SEL_CTRL = 2'd2,
    SEL_NONE = 2'd3   // Unmapped, acked by the fabric
  } slave_sel_e;

endpackage

// ==== logic/soc_ctrl_pkg.sv ====
// Reset and control types
// Reset sequencer states and the software control register layout

package soc_ctrl_pkg;

  typedef enum logic [1:0] {
    RST_HOLD  = 2'd0,   // Held in reset
    RST_COUNT = 2'd1,
    RST_RUN   = 2'd2
  } rst_state_e;

  // Control register, bit 3 cpu reset and bit 7 system reset
  typedef struct packed {
    logic [7:0] scratch_hi;
    logic       sys_rst;
    logic [2:0] scratch_mid;
    logic       cpu_rst;
    logic [2:0] scratch_lo;
  } sys_ctl_t;

endpackage

// ==== logic/slave_bus_if.sv ====
// Decoded slave access
// One per slave; the fabric drives the request, the slave answers with
// a one-cycle ready and its read data

`timescale 1ns/1ps

interface slave_bus_if;
  import soc_bus_pkg::*;

  logic      sel;     // Request decoded for this slave
  bus_word_t addr;
  bus_word_t wdata;
  bus_strb_t wstrb;
  logic      ready;
  bus_word_t rdata;

  modport fabric (
    output sel,
    output addr,
    output wdata,
    output wstrb,
    input  ready,
    input  rdata
  );

  modport slave (
    input  sel,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready,
    output rdata
  );

endinterface

// ==== logic/sys_bus.sv ====
// System bus fabric
// Decodes the master address into one of three slaves or the unmapped
// region, drives the slave selects and merges ready and read data

`timescale 1ns/1ps
`include "soc_macros.svh"

module sys_bus (
  input  logic                   sys_clk,
  input  logic                   soc_resetn,
  input  logic                   mem_valid,
  input  soc_bus_pkg::bus_word_t mem_addr,
  input  soc_bus_pkg::bus_word_t mem_wdata,
  input  soc_bus_pkg::bus_strb_t mem_wstrb,
  output logic                   mem_ready,
  output soc_bus_pkg::bus_word_t mem_rdata,
  slave_bus_if.fabric            mem_port,
  slave_bus_if.fabric            gpio_port,
  slave_bus_if.fabric            ctrl_port
);
  import soc_bus_pkg::*;

  localparam bus_word_t MEM_BASE  = `SOC_MEM_BASE;
  localparam bus_word_t GPIO_BASE = `SOC_GPIO_BASE;
  localparam bus_word_t CTRL_BASE = `SOC_CTRL_BASE;

  slave_sel_e dec_sel;
  slave_sel_e sel_q;      // Selection of the access being acked
  logic       req_ok;
  logic       none_ack;
  bus_word_t  rd_mux;

  // Address decode =========================
  always_comb begin
    dec_sel = SEL_NONE;
    if (mem_addr[31:28] == MEM_BASE[31:28]) begin
      dec_sel = SEL_MEM;
    end else if (mem_addr[31:28] == GPIO_BASE[31:28]) begin
      dec_sel = SEL_GPIO;
    end else if (mem_addr[31:28] == CTRL_BASE[31:28]) begin
      dec_sel = SEL_CTRL;
    end
  end

  assign req_ok = mem_valid & soc_resetn;   // No requests during reset

  assign mem_port.sel   = req_ok & (dec_sel == SEL_MEM);
  assign mem_port.addr  = mem_addr;
  assign mem_port.wdata = mem_wdata;
  assign mem_port.wstrb = mem_wstrb;

  assign gpio_port.sel   = req_ok & (dec_sel == SEL_GPIO);
  assign gpio_port.addr  = mem_addr;
  assign gpio_port.wdata = mem_wdata;
  assign gpio_port.wstrb = mem_wstrb;

  assign ctrl_port.sel   = req_ok & (dec_sel == SEL_CTRL);
  assign ctrl_port.addr  = mem_addr;
  assign ctrl_port.wdata = mem_wdata;
  assign ctrl_port.wstrb = mem_wstrb;

  // Unmapped ack and response select =======
  always_ff @(posedge sys_clk) begin
    if (!soc_resetn) begin
      none_ack <= 1'b0;
      sel_q    <= SEL_NONE;
    end else begin
      none_ack <= req_ok & (dec_sel == SEL_NONE) & ~none_ack;
      sel_q    <= dec_sel;
    end
  end

  always_comb begin
    case (sel_q)
      SEL_MEM:  rd_mux = mem_port.rdata;
      SEL_GPIO: rd_mux = gpio_port.rdata;
      SEL_CTRL: rd_mux = ctrl_port.rdata;
      default:  rd_mux = '0;   // Unmapped reads as zero
    endcase
  end

  assign mem_ready = mem_port.ready | gpio_port.ready | ctrl_port.ready | none_ack;
  assign mem_rdata = mem_ready ? rd_mux : '0;

endmodule

// ==== logic/onchip_mem.sv ====
// On-chip word memory
// Byte-strobe writes and registered reads, acked one cycle after select

`timescale 1ns/1ps
`include "soc_macros.svh"

module onchip_mem (
  input logic        sys_clk,
  slave_bus_if.slave bus
);
  import soc_bus_pkg::*;

  localparam int AW = $clog2(`SOC_MEM_WORDS);

  bus_word_t     mem [`SOC_MEM_WORDS];
  logic [AW-1:0] idx;
  logic          access;
  logic          ready_q;
  bus_word_t     rdata_q;

  assign idx    = bus.addr[AW+1:2];   // Upper bits alias
  assign access = bus.sel & ~ready_q; // Not yet acked

  // One-cycle ack after the first cycle of sel
  always_ff @(posedge sys_clk) begin
    ready_q <= access;
  end

  // Storage ================================
  always_ff @(posedge sys_clk) begin
    if (access) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.wstrb[i]) begin
          mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      rdata_q <= mem[idx];
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

endmodule

// ==== logic/gpio_regs.sv ====
// GPIO register block
// Offset 0 reads the synchronized DIP switches, offset 4 holds the LEDs

`timescale 1ns/1ps

module gpio_regs (
  input  logic       sys_clk,
  input  logic       soc_resetn,
  slave_bus_if.slave bus,
  input  logic [2:0] user_dip,
  output logic [3:0] user_led
);
  import soc_bus_pkg::*;

  localparam logic [25:0] OFS_DIP = 26'd0;
  localparam logic [25:0] OFS_LED = 26'd1;

  logic [2:0]  dip_meta;
  logic [2:0]  dip_sync;
  logic [25:0] word;
  logic        access;
  logic        ready_q;
  logic [3:0]  led_q;
  bus_word_t   rdata_q;

  assign word   = bus.addr[27:2];
  assign access = bus.sel & ~ready_q;

  // Two-flop DIP synchronizer
  always_ff @(posedge sys_clk) begin
    dip_meta <= user_dip;
    dip_sync <= dip_meta;
  end

  always_ff @(posedge sys_clk) begin
    if (!soc_resetn) begin
      ready_q <= 1'b0;
      led_q   <= 4'd0;
    end else begin
      ready_q <= access;
      if (access && bus.wstrb[0] && word == OFS_LED) begin
        led_q <= bus.wdata[3:0];
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (access) begin
      case (word)
        OFS_DIP: rdata_q <= {29'd0, dip_sync};
        OFS_LED: rdata_q <= {28'd0, led_q};
        default: rdata_q <= '0;
      endcase
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;
  assign user_led  = led_q;

endmodule

// ==== logic/sys_ctrl.sv ====
// System control registers
// Software control register at offset 0 with the cpu and system reset
// requests, read-only ID at offset 4

`timescale 1ns/1ps
`include "soc_macros.svh"

module sys_ctrl (
  input  logic       sys_clk,
  input  logic       soc_resetn,
  slave_bus_if.slave bus,
  output logic       sys_rst_req,
  output logic       cpu_rst_req
);
  import soc_ctrl_pkg::*;

  localparam logic [25:0] OFS_CTL = 26'd0;
  localparam logic [25:0] OFS_ID  = 26'd1;

  logic [25:0] word;
  logic        access;
  logic        ready_q;
  sys_ctl_t    ctl_q;
  logic [31:0] rdata_q;

  assign word   = bus.addr[27:2];
  assign access = bus.sel & ~ready_q;

  always_ff @(posedge sys_clk) begin
    if (!soc_resetn) begin
      ready_q <= 1'b0;
      ctl_q   <= '0;
    end else begin
      ready_q <= access;
      if (access && word == OFS_CTL) begin
        if (bus.wstrb[0]) ctl_q[7:0]  <= bus.wdata[7:0];
        if (bus.wstrb[1]) ctl_q[15:8] <= bus.wdata[15:8];
      end
    end
  end

  // Read path ==============================
  always_ff @(posedge sys_clk) begin
    if (access) begin
      case (word)
        OFS_CTL: rdata_q <= {16'd0, ctl_q};
        OFS_ID:  rdata_q <= `SOC_ID_VALUE;
        default: rdata_q <= '0;
      endcase
    end
  end

  assign bus.ready   = ready_q;
  assign bus.rdata   = rdata_q;
  assign sys_rst_req = ctl_q[`CTL_SYS_RST_BIT];
  assign cpu_rst_req = ctl_q[`CTL_CPU_RST_BIT];

endmodule

// ==== logic/reset_ctrl.sv ====
// Reset sequencer
// Holds the internal reset for SOC_RST_CYCLES after board reset or a
// software system reset, and derives the registered cpu reset

`timescale 1ns/1ps
`include "soc_macros.svh"

module reset_ctrl (
  input  logic sys_clk,
  input  logic resetn,
  input  logic sys_rst_req,
  input  logic cpu_rst_req,
  output logic soc_resetn,
  output logic cpu_resetn
);
  import soc_ctrl_pkg::*;

  localparam int               CNT_W    = $clog2(`SOC_RST_CYCLES);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SOC_RST_CYCLES - 1);

  rst_state_e       state;
  logic [CNT_W-1:0] cnt;

  // Sequencer FSM ==========================
  always_ff @(posedge sys_clk) begin
    if (!resetn || sys_rst_req) begin
      state      <= RST_HOLD;
      cnt        <= '0;
      cpu_resetn <= 1'b0;
    end else begin
      cpu_resetn <= (state == RST_RUN) & ~cpu_rst_req;
      case (state)
        RST_HOLD: begin
          state <= RST_COUNT;
          cnt   <= '0;
        end
        RST_COUNT: begin
          if (cnt == CNT_LAST) begin
            state <= RST_RUN;   // Release on the count's last edge
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RST_RUN: state <= RST_RUN;
        default: state <= RST_HOLD;
      endcase
    end
  end

  assign soc_resetn = (state == RST_RUN);

endmodule

// ==== logic/mx_soc.sv ====
// SoC bus fabric top level
// Bus master ports in, decoder with memory, GPIO and system control
// slaves, plus the reset sequencer

`timescale 1ns/1ps

module mx_soc (
  input  logic                   sys_clk,
  input  logic                   resetn,
  input  logic                   mem_valid,
  input  soc_bus_pkg::bus_word_t mem_addr,
  input  soc_bus_pkg::bus_word_t mem_wdata,
  input  soc_bus_pkg::bus_strb_t mem_wstrb,
  input  logic [2:0]             user_dip,
  output logic                   mem_ready,
  output soc_bus_pkg::bus_word_t mem_rdata,
  output logic [3:0]             user_led,
  output logic                   cpu_resetn
);

  logic soc_resetn;
  logic sys_rst_req;
  logic cpu_rst_req;

  slave_bus_if mem_bus ();
  slave_bus_if gpio_bus ();
  slave_bus_if ctrl_bus ();

  reset_ctrl i_reset_ctrl (
    .sys_clk     (sys_clk),
    .resetn      (resetn),
    .sys_rst_req (sys_rst_req),
    .cpu_rst_req (cpu_rst_req),
    .soc_resetn  (soc_resetn),
    .cpu_resetn  (cpu_resetn)
  );

  sys_bus i_sys_bus (
    .sys_clk    (sys_clk),
    .soc_resetn (soc_resetn),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .mem_port   (mem_bus),
    .gpio_port  (gpio_bus),
    .ctrl_port  (ctrl_bus)
  );

  // Slaves =================================
  onchip_mem i_onchip_mem (
    .sys_clk (sys_clk),
    .bus     (mem_bus)
  );

  gpio_regs i_gpio_regs (
    .sys_clk    (sys_clk),
    .soc_resetn (soc_resetn),
    .bus        (gpio_bus),
    .user_dip   (user_dip),
    .user_led   (user_led)
  );

  sys_ctrl i_sys_ctrl (
    .sys_clk     (sys_clk),
    .soc_resetn  (soc_resetn),
    .bus         (ctrl_bus),
    .sys_rst_req (sys_rst_req),
    .cpu_rst_req (cpu_rst_req)
  );

endmodule

// ==== bench/tb_mx_soc.sv ====
// Testbench for the SoC bus fabric
// Random bus traffic from a fixed seed, checked against a reference model
// of the memory, the LED register and the control register

`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_mx_soc;
  import soc_bus_pkg::*;

  localparam int ACK_LIMIT   = 20;
  localparam int TIMEOUT_CYC = 20000;   // About 2800 two-cycle accesses and three resets
  localparam int WIN_WORDS   = `SOC_MEM_WORDS;   // Memory words under test

  logic       sys_clk;
  logic       resetn;
  logic       mem_valid;
  bus_word_t  mem_addr;
  bus_word_t  mem_wdata;
  bus_strb_t  mem_wstrb;
  logic [2:0] user_dip;
  logic       mem_ready;
  bus_word_t  mem_rdata;
  logic [3:0] user_led;
  logic       cpu_resetn;

  integer      seed      = 28;
  int          err_cnt   = 0;
  int          check_cnt = 0;
  int          cycle_cnt = 0;
  bus_word_t   model_mem [WIN_WORDS];
  logic [3:0]  model_led;
  logic [15:0] model_ctl;

  mx_soc i_mx_soc (
    .sys_clk    (sys_clk),
    .resetn     (resetn),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .user_dip   (user_dip),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .user_led   (user_led),
    .cpu_resetn (cpu_resetn)
  );

  always #5 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Simulation timed out after %0d cycles", cycle_cnt);
      $display("Checks: %0d  Errors: %0d", check_cnt, err_cnt + 1);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Helpers ================================
  task automatic expect_word(input string name, input bus_word_t got, input bus_word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // One access, started 1 ns after an edge, ends 1 ns after an idle edge
  task automatic bus_access(input bus_word_t addr, input bus_word_t data,
                            input bus_strb_t strb, input int max_wait,
                            output bus_word_t rdata, output int latency);
    int   n;
    logic acked;
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = data;
    mem_wstrb = strb;
    n         = 0;
    acked     = 1'b0;
    rdata     = '0;
    while (!acked && n < max_wait) begin
      @(posedge sys_clk);
      #1;
      n++;
      if (mem_ready) begin
        acked = 1'b1;
        rdata = mem_rdata;
      end
    end
    mem_valid = 1'b0;
    mem_wstrb = '0;
    latency   = n;
    if (!acked) begin
      err_cnt++;
      $display("Bus access to address %h was never acknowledged", addr);
    end
    @(posedge sys_clk);
    #1;
  endtask

  task automatic write_word(input bus_word_t addr, input bus_word_t data, input bus_strb_t strb);
    bus_word_t rd;
    int        lat;
    bus_access(addr, data, strb, ACK_LIMIT, rd, lat);
    expect_word("mem_ready latency", bus_word_t'(lat), 1);
  endtask

  task automatic read_word(input bus_word_t addr, output bus_word_t data);
    int lat;
    bus_access(addr, '0, 4'h0, ACK_LIMIT, data, lat);
    expect_word("mem_ready latency", bus_word_t'(lat), 1);
  endtask

  function automatic bus_word_t merge_bytes(bus_word_t old, bus_word_t data, bus_strb_t strb);
    bus_word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // Memory address with random upper bits that alias onto word idx
  function automatic bus_word_t mem_alias_addr(int idx);
    bus_word_t r;
    r = $random(seed);
    return {4'h0, r[27:12], idx[9:0], 2'b00};
  endfunction

  initial begin
    bus_word_t rd;
    bus_word_t wd;
    bus_word_t ad;
    bus_strb_t st;
    int        idx;
    int        lat;
    int        n;
    int        i;
    sys_clk   = 1'b0;
    resetn    = 1'b0;
    mem_valid = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    user_dip  = 3'd0;
    model_led = 4'd0;
    model_ctl = 16'd0;

    // Reset release ==========================
    repeat (8) @(posedge sys_clk);
    #1;
    expect_word("mem_ready", 32'(mem_ready), 0);
    expect_word("user_led", 32'(user_led), 0);
    expect_word("cpu_resetn", 32'(cpu_resetn), 0);
    resetn = 1'b1;
    n = 0;
    while (!cpu_resetn && n < 200) begin
      @(posedge sys_clk);
      #1;
      n++;
    end
    if (!cpu_resetn) begin
      err_cnt++;
      $display("cpu_resetn was never released after board reset");
    end else if (n < 99 || n > 102) begin
      err_cnt++;
      $display("ERROR cpu_resetn release cycle: got %h expected %h to %h", n, 99, 102);
    end

    // Memory =================================
    for (i = 0; i < WIN_WORDS; i++) begin
      wd = $random(seed);
      write_word(mem_alias_addr(i), wd, 4'hF);
      model_mem[i] = wd;
    end
    for (i = 0; i < 300; i++) begin
      idx = {$random(seed)} % WIN_WORDS;
      wd  = $random(seed);
      st  = 4'({$random(seed)} % 15 + 1);   // Never a read
      write_word(mem_alias_addr(idx), wd, st);
      model_mem[idx] = merge_bytes(model_mem[idx], wd, st);
      idx = {$random(seed)} % WIN_WORDS;
      read_word(mem_alias_addr(idx), rd);
      expect_word("mem_rdata", rd, model_mem[idx]);
    end

    // GPIO ===================================
    for (i = 0; i < 20; i++) begin
      wd = $random(seed);
      st = 4'({$random(seed)} % 15 + 1);
      write_word(`SOC_GPIO_BASE + 32'h4, wd, st);
      if (st[0]) model_led = wd[3:0];
      read_word(`SOC_GPIO_BASE + 32'h4, rd);
      expect_word("led_reg", rd, 32'(model_led));
      expect_word("user_led", 32'(user_led), 32'(model_led));
      user_dip = 3'($random(seed));
      repeat (3) @(posedge sys_clk);
      #1;
      read_word(`SOC_GPIO_BASE, rd);
      expect_word("dip_reg", rd, 32'(user_dip));
    end

    // CPU reset bit
    wd = $random(seed);
    wd[`CTL_CPU_RST_BIT] = 1'b1;
    wd[`CTL_SYS_RST_BIT] = 1'b0;
    write_word(`SOC_CTRL_BASE, wd, 4'b0011);
    model_ctl = wd[15:0];
    repeat (2) @(posedge sys_clk);
    #1;
    expect_word("cpu_resetn", 32'(cpu_resetn), 0);
    for (i = 0; i < 10; i++) begin
      idx = {$random(seed)} % WIN_WORDS;
      wd  = $random(seed);
      st  = 4'({$random(seed)} % 15 + 1);
      write_word(mem_alias_addr(idx), wd, st);
      model_mem[idx] = merge_bytes(model_mem[idx], wd, st);
      read_word(mem_alias_addr(idx), rd);
      expect_word("mem_rdata", rd, model_mem[idx]);
    end
    read_word(`SOC_CTRL_BASE, rd);
    expect_word("ctl_reg", rd, 32'(model_ctl));
    read_word(`SOC_CTRL_BASE + 32'h4, rd);
    expect_word("id_reg", rd, `SOC_ID_VALUE);
    expect_word("cpu_resetn", 32'(cpu_resetn), 0);
    model_ctl[`CTL_CPU_RST_BIT] = 1'b0;
    write_word(`SOC_CTRL_BASE, 32'(model_ctl), 4'b0011);
    repeat (2) @(posedge sys_clk);
    #1;
    expect_word("cpu_resetn", 32'(cpu_resetn), 1);

    // Unmapped region ========================
    for (i = 0; i < 20; i++) begin
      ad = $random(seed);
      ad[31:28] = 4'({$random(seed)} % 13 + 3);
      read_word(ad, rd);
      expect_word("mem_rdata", rd, 0);
      wd = $random(seed);
      write_word(ad, wd, 4'hF);
      idx = int'(ad[11:2]);   // Word the write would hit if it aliased
      read_word(mem_alias_addr(idx), rd);
      expect_word("mem_rdata", rd, model_mem[idx]);
    end

    // System reset ===========================
    write_word(`SOC_GPIO_BASE + 32'h4, 32'hF, 4'h1);
    model_led = 4'hF;
    expect_word("user_led", 32'(user_led), 32'(model_led));
    wd = $random(seed);
    wd[`CTL_SYS_RST_BIT] = 1'b1;
    wd[`CTL_CPU_RST_BIT] = 1'b0;
    write_word(`SOC_CTRL_BASE, wd, 4'b0011);
    expect_word("cpu_resetn", 32'(cpu_resetn), 0);
    idx = {$random(seed)} % WIN_WORDS;
    bus_access(mem_alias_addr(idx), '0, 4'h0, 200, rd, lat);   // Stalls until release
    if (lat < `SOC_RST_CYCLES - 5 || lat > `SOC_RST_CYCLES + 10) begin
      err_cnt++;
      $display("ERROR stall latency: got %h expected about %h", lat, `SOC_RST_CYCLES);
    end
    expect_word("mem_rdata", rd, model_mem[idx]);
    expect_word("cpu_resetn", 32'(cpu_resetn), 1);
    model_ctl = 16'd0;
    model_led = 4'd0;
    read_word(`SOC_CTRL_BASE, rd);
    expect_word("ctl_reg", rd, 32'(model_ctl));
    read_word(`SOC_GPIO_BASE + 32'h4, rd);
    expect_word("led_reg", rd, 32'(model_led));
    expect_word("user_led", 32'(user_led), 32'(model_led));
    for (i = 0; i < WIN_WORDS; i++) begin
      read_word(mem_alias_addr(i), rd);
      expect_word("mem_rdata", rd, model_mem[i]);
    end

    $display("Checks: %0d  Errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
logic/soc_bus_pkg.sv
logic/soc_ctrl_pkg.sv
logic/slave_bus_if.sv
logic/sys_bus.sv
logic/onchip_mem.sv
logic/gpio_regs.sv
logic/sys_ctrl.sv
logic/reset_ctrl.sv
logic/mx_soc.sv
bench/tb_mx_soc.sv

// ==== run.sh ====
#!/bin/sh
# Compile the bus fabric testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_mx_soc -f tb.f \
  && ./obj_dir/Vtb_mx_soc | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
